// File: logic/shell_pkg.sv
`default_nettype none

package shell_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] insn_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] irq_t;
    typedef logic [4:0]  irq_cause_t;
    typedef logic [3:0]  mem_mask_t;

    // CSR addresses and the global interrupt enable inside mstatus
    localparam csr_addr_t CSR_MSTATUS     = 12'h300;
    localparam csr_addr_t CSR_MIE         = 12'h304;
    localparam int        MSTATUS_MIE_BIT = 3;

    localparam insn_t INSN_DRET = 32'h7b200073;

    // Shadow pipeline geometry
    localparam int PIPELINE_DEPTH = 4;
    localparam int FILL_CNT_W     = $clog2(PIPELINE_DEPTH);
    localparam int STAGE_IF       = 0;
    localparam int STAGE_ID       = 1;
    localparam int STAGE_EX       = 2;
    localparam int STAGE_WB       = 3;

    // Up to this many memory operations may be outstanding in the LSU
    localparam int LSU_DEPTH = 2;
    localparam int LSU_CNT_W = $clog2(LSU_DEPTH + 1);

    // A retired instruction carries at most this many CSR writes
    localparam int CSR_WR_N = 2;

    ////////////////////////////////////////////////////////////
    // Records
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        xlen_t     wdata;
    } csr_wr_t;

    typedef struct packed {
        insn_t                    insn;
        csr_wr_t [CSR_WR_N-1:0]   csr_wr;
        mem_mask_t                rmask;
        mem_mask_t                wmask;
        logic                     dbg_mode;
    } insn_rec_t;

    typedef struct packed {
        logic      valid;
        insn_rec_t rec;
    } stage_t;

    // One step bit and one flush bit per stage, indexed by STAGE_*
    typedef struct packed {
        logic [PIPELINE_DEPTH-1:0] step;
        logic [PIPELINE_DEPTH-1:0] flush;
    } stage_step_t;

endpackage

`default_nettype wire

// File: logic/shell_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module shell_pipeline (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire shell_pkg::stage_step_t  ctrl_i,
    input  wire shell_pkg::insn_rec_t    rec_i,
    input  wire logic                    valid_i,
    output shell_pkg::stage_t            ex_o,
    output shell_pkg::stage_t            exwb_o,
    output shell_pkg::stage_t            wb_o
);
    import shell_pkg::*;

    // Stage k holds what stage k has produced, so index STAGE_ID is the
    // ID/EX register and carries the record that is executing in EX
    logic      vld_q [PIPELINE_DEPTH];
    insn_rec_t rec_q [PIPELINE_DEPTH];

    for (genvar g = 0; g < PIPELINE_DEPTH; g++) begin : g_stage
        logic      vld_in;
        insn_rec_t rec_in;

        // IF is fed from the retire port, every later stage from its predecessor
        if (g == STAGE_IF) begin : g_head
            assign vld_in = valid_i;
            assign rec_in = rec_i;
        end else begin : g_body
            assign vld_in = vld_q[g-1];
            assign rec_in = rec_q[g-1];
        end

        // A flush wins over a step and leaves the stage empty
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                vld_q[g] <= 1'b0;
            end else if (ctrl_i.flush[g]) begin
                vld_q[g] <= 1'b0;
            end else if (ctrl_i.step[g]) begin
                vld_q[g] <= vld_in;
            end
        end

        // Record payload only moves on a real step
        always_ff @(posedge clk) begin
            if (ctrl_i.step[g] && !ctrl_i.flush[g]) begin
                rec_q[g] <= rec_in;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Taps for the controller
    ////////////////////////////////////////////////////////////

    assign ex_o   = {vld_q[STAGE_ID], rec_q[STAGE_ID]};
    // This one enters WB on the next step
    assign exwb_o = {vld_q[STAGE_EX], rec_q[STAGE_EX]};
    assign wb_o   = {vld_q[STAGE_WB], rec_q[STAGE_WB]};

endmodule

`default_nettype wire

// File: logic/csr_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module csr_tracker (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               step_i,
    input  wire shell_pkg::stage_t  exwb_i,
    input  wire logic               irq_taken_i,
    output shell_pkg::irq_t         mie_o,
    output logic                    irq_enabled_o
);
    import shell_pkg::*;

    logic mie_wr;
    logic mstatus_set;
    irq_t mie_wdata;

    // CSR effects must land when the record reaches WB, as they do in the core
    always_comb begin
        mie_wr      = 1'b0;
        mstatus_set = 1'b0;
        mie_wdata   = '0;
        for (int i = 0; i < CSR_WR_N; i++) begin
            if (exwb_i.valid && exwb_i.rec.csr_wr[i].valid) begin
                if (exwb_i.rec.csr_wr[i].addr == CSR_MIE) begin
                    mie_wr    = 1'b1;
                    mie_wdata = irq_t'(exwb_i.rec.csr_wr[i].wdata);
                end
                // Only a write that sets mstatus.MIE matters here
                if (exwb_i.rec.csr_wr[i].addr == CSR_MSTATUS &&
                    exwb_i.rec.csr_wr[i].wdata[MSTATUS_MIE_BIT]) begin
                    mstatus_set = 1'b1;
                end
            end
        end
    end

    // Shadow copy of mie, loaded as the writing record moves into WB
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_o <= '0;
        end else if (step_i && mie_wr) begin
            mie_o <= mie_wdata;
        end
    end

    // Trap entry clears MIE, so the enable goes away the cycle after a take
    // and comes back only with a fresh mstatus write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_enabled_o <= 1'b0;
        end else if (step_i && mstatus_set) begin
            irq_enabled_o <= 1'b1;
        end else if (irq_taken_i) begin
            irq_enabled_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/irq_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               step_i,
    input  wire logic               prev_step_i,
    input  wire shell_pkg::stage_t  ex_i,
    input  wire shell_pkg::irq_t    irq_i,
    input  wire shell_pkg::irq_t    mie_i,
    input  wire logic               irq_enabled_i,
    input  wire logic               debug_mode_i,
    output logic                    irq_taken_o,
    output shell_pkg::irq_cause_t   irq_cause_o
);
    import shell_pkg::*;

    irq_t                 irq_q;
    irq_t                 irq_qq;
    irq_t                 irq_masked;
    logic [LSU_CNT_W-1:0] lsu_cnt_q;
    logic                 mem_in_ex;
    logic                 lsu_up;
    logic                 lsu_down;
    logic                 take;
    irq_cause_t           cause;

    // Two flops on the irq lines line them up with the core after its flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q  <= '0;
            irq_qq <= '0;
        end else begin
            irq_q  <= irq_i;
            irq_qq <= irq_q;
        end
    end

    ////////////////////////////////////////////////////////////
    // LSU occupancy
    ////////////////////////////////////////////////////////////

    assign mem_in_ex = ex_i.valid && ((|ex_i.rec.rmask) || (|ex_i.rec.wmask));

    // A memory record counts up the cycle after it arrives in EX
    assign lsu_up   = mem_in_ex && prev_step_i;
    // and down when it moves on towards WB
    assign lsu_down = mem_in_ex && step_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lsu_cnt_q <= '0;
        end else if (!ex_i.valid) begin
            // A flushed or empty EX leaves nothing outstanding
            lsu_cnt_q <= '0;
        end else begin
            case ({lsu_up, lsu_down})
                2'b10: begin
                    if (lsu_cnt_q < LSU_CNT_W'(LSU_DEPTH)) begin
                        lsu_cnt_q <= lsu_cnt_q + 1'b1;
                    end
                end
                2'b01: begin
                    if (lsu_cnt_q != '0) begin
                        lsu_cnt_q <= lsu_cnt_q - 1'b1;
                    end
                end
                default: begin
                    lsu_cnt_q <= lsu_cnt_q;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Take decision
    ////////////////////////////////////////////////////////////

    assign irq_masked = irq_qq & mie_i;

    // Lowest pending index wins
    always_comb begin
        cause = '0;
        for (int i = $bits(irq_t) - 1; i >= 0; i--) begin
            if (irq_masked[i]) begin
                cause = irq_cause_t'(i);
            end
        end
    end

    // The enable is still high for one cycle after a take, hence the last term
    assign take = (|irq_masked) && irq_enabled_i && (lsu_cnt_q == '0) &&
                  !debug_mode_i && !irq_taken_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_taken_o <= 1'b0;
            irq_cause_o <= '0;
        end else begin
            irq_taken_o <= take;
            if (take) begin
                irq_cause_o <= cause;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/debug_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module debug_ctrl (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               debug_req_i,
    input  wire shell_pkg::stage_t  wb_i,
    input  wire logic               pipeline_full_i,
    output logic                    debug_mode_o,
    output logic                    debug_taken_o
);
    import shell_pkg::*;

    logic debug_mode_q;
    logic debug_req_q;
    logic debug_req_qq;
    logic req_rise;

    // The retired dret still carries dbg_mode, but the core has left debug
    // mode by then, so dret clears it right away
    // Between valid WB records the last known mode is kept
    assign debug_mode_o = wb_i.valid ?
                          (wb_i.rec.dbg_mode && (wb_i.rec.insn != INSN_DRET)) :
                          debug_mode_q;

    assign req_rise = debug_req_q && !debug_req_qq;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_mode_q  <= 1'b0;
            debug_req_q   <= 1'b0;
            debug_req_qq  <= 1'b0;
            debug_taken_o <= 1'b0;
        end else begin
            debug_mode_q  <= debug_mode_o;
            debug_req_q   <= debug_req_i;
            debug_req_qq  <= debug_req_q;
            // No debug entry while still filling after reset or a flush
            debug_taken_o <= req_rise && !debug_mode_o && pipeline_full_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/shell_controller.sv
`timescale 1ns/1ps
`default_nettype none

module shell_controller (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    valid_i,
    input  wire shell_pkg::irq_t         irq_i,
    input  wire logic                    debug_req_i,
    input  wire shell_pkg::stage_t       ex_i,
    input  wire shell_pkg::stage_t       exwb_i,
    input  wire shell_pkg::stage_t       wb_i,
    output shell_pkg::stage_step_t       ctrl_o,
    output logic                         irq_taken_o,
    output shell_pkg::irq_cause_t        irq_cause_o,
    output logic                         debug_taken_o,
    output logic                         flush_o
);
    import shell_pkg::*;

    logic [FILL_CNT_W-1:0] fill_cnt_q;
    logic                  pipeline_full;
    logic                  step;
    logic                  front_step;
    logic                  front_step_q;
    logic                  debug_taken_q;
    irq_t                  mie;
    logic                  irq_enabled;
    logic                  debug_mode;

    ////////////////////////////////////////////////////////////
    // Step control
    ////////////////////////////////////////////////////////////

    // Full once IF, ID and EX hold something, which keeps us in step with the core
    assign pipeline_full = (fill_cnt_q >= FILL_CNT_W'(PIPELINE_DEPTH - 1));

    // Restart the fill after every flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt_q <= '0;
        end else if (flush_o) begin
            fill_cnt_q <= '0;
        end else if (!pipeline_full) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
        end
    end

    // Free-run while filling, afterwards only on a retired record
    assign step = !pipeline_full || valid_i;

    // Debug entry halts the front end and lets WB drain
    assign front_step = step && !debug_taken_o;

    always_comb begin
        for (int i = 0; i < PIPELINE_DEPTH; i++) begin
            ctrl_o.step[i] = (i == STAGE_WB) ? step : front_step;
        end
        ctrl_o.flush = {PIPELINE_DEPTH{flush_o}};
    end

    ////////////////////////////////////////////////////////////
    // Flush control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_taken_q <= 1'b0;
            front_step_q  <= 1'b0;
        end else begin
            debug_taken_q <= debug_taken_o;
            // Tells the LSU counter that EX was loaded on the last edge
            front_step_q  <= front_step;
        end
    end

    assign flush_o = irq_taken_o || debug_taken_q;

    ////////////////////////////////////////////////////////////
    // Decision blocks
    ////////////////////////////////////////////////////////////

    csr_tracker u_csr_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .step_i        (step),
        .exwb_i        (exwb_i),
        .irq_taken_i   (irq_taken_o),
        .mie_o         (mie),
        .irq_enabled_o (irq_enabled)
    );

    irq_arbiter u_irq_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .step_i        (front_step),
        .prev_step_i   (front_step_q),
        .ex_i          (ex_i),
        .irq_i         (irq_i),
        .mie_i         (mie),
        .irq_enabled_i (irq_enabled),
        .debug_mode_i  (debug_mode),
        .irq_taken_o   (irq_taken_o),
        .irq_cause_o   (irq_cause_o)
    );

    debug_ctrl u_debug_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .debug_req_i     (debug_req_i),
        .wb_i            (wb_i),
        .pipeline_full_i (pipeline_full),
        .debug_mode_o    (debug_mode),
        .debug_taken_o   (debug_taken_o)
    );

endmodule

`default_nettype wire

// File: logic/shell_top.sv
`timescale 1ns/1ps
`default_nettype none

module shell_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  valid_i,
    input  wire shell_pkg::insn_rec_t  rec_i,
    input  wire shell_pkg::irq_t       irq_i,
    input  wire logic                  debug_req_i,
    output shell_pkg::stage_t          wb_o,
    output logic                       irq_taken_o,
    output shell_pkg::irq_cause_t      irq_cause_o,
    output logic                       debug_taken_o,
    output logic                       flush_o
);
    import shell_pkg::*;

    stage_step_t ctrl;
    stage_t      ex_rec;
    stage_t      exwb_rec;

    // Controller decides step and flush from what the stages hold
    shell_controller u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid_i),
        .irq_i         (irq_i),
        .debug_req_i   (debug_req_i),
        .ex_i          (ex_rec),
        .exwb_i        (exwb_rec),
        .wb_i          (wb_o),
        .ctrl_o        (ctrl),
        .irq_taken_o   (irq_taken_o),
        .irq_cause_o   (irq_cause_o),
        .debug_taken_o (debug_taken_o),
        .flush_o       (flush_o)
    );

    shell_pipeline u_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl_i  (ctrl),
        .rec_i   (rec_i),
        .valid_i (valid_i),
        .ex_o    (ex_rec),
        .exwb_o  (exwb_rec),
        .wb_o    (wb_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // Half of the 4 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

    // Reset covers 16 rising edges and lets go right at the last one
    initial begin
        rst_n_o = 1'b0;
        repeat (16) begin
            @(posedge clk_o);
        end
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/shell_tb.sv
`timescale 1ns/1ps
`default_nettype none

module shell_tb;
    import shell_pkg::*;

    localparam int    WAIT_LIMIT  = 50;
    localparam xlen_t MSTATUS_MIE = xlen_t'(1) << MSTATUS_MIE_BIT;

    logic       clk;
    logic       rst_n;
    logic       valid;
    insn_rec_t  rec;
    irq_t       irq;
    logic       debug_req;
    stage_t     wb;
    logic       irq_taken;
    irq_cause_t irq_cause;
    logic       debug_taken;
    logic       flush;

    int          err_cnt;
    int          test_err_base;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] lfsr_q;

    // Expected contents of the four stages with IF at index 0
    logic  exp_vld  [PIPELINE_DEPTH];
    insn_t exp_insn [PIPELINE_DEPTH];

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    shell_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid),
        .rec_i         (rec),
        .irq_i         (irq),
        .debug_req_i   (debug_req),
        .wb_o          (wb),
        .irq_taken_o   (irq_taken),
        .irq_cause_o   (irq_cause),
        .debug_taken_o (debug_taken),
        .flush_o       (flush)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // Right-shifting Galois LFSR with taps for x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit of the word
    function automatic insn_t rand_insn();
        insn_t w;
        for (int i = 0; i < $bits(insn_t); i++) begin
            w[i]   = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
        return w;
    endfunction

    function automatic insn_rec_t make_rec(input insn_t insn, input logic dbg);
        insn_rec_t r;
        r          = '0;
        r.insn     = insn;
        r.dbg_mode = dbg;
        return r;
    endfunction

    function automatic csr_wr_t csr_write(input csr_addr_t addr, input xlen_t data);
        csr_wr_t w;
        w.valid = 1'b1;
        w.addr  = addr;
        w.wdata = data;
        return w;
    endfunction

    // One clock cycle that ends 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_insn(input string name, input insn_t got, input insn_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_cause(input string name, input irq_cause_t got,
                               input irq_cause_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    // An expected delay of zero accepts any delay inside the limit
    task automatic expect_pulse(input string what, input int cycles, input int exp);
        if (cycles < 0) begin
            $display("%s did not rise within %0d cycles", what, WAIT_LIMIT);
            err_cnt++;
        end else if (exp > 0 && cycles != exp) begin
            $display("%s rose after %0d cycles instead of %0d", what, cycles, exp);
            err_cnt++;
        end
    endtask

    task automatic expect_no_pulse(input string what, input int cycles);
        if (cycles >= 0) begin
            $display("%s rose after %0d cycles but should have stayed low", what, cycles);
            err_cnt++;
        end
    endtask

    task automatic check_wb();
        check_bit("wb_o.valid", wb.valid, exp_vld[STAGE_WB]);
        if (exp_vld[STAGE_WB]) begin
            check_insn("wb_o.rec.insn", wb.rec.insn, exp_insn[STAGE_WB]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Pipeline movement
    ////////////////////////////////////////////////////////////

    // Once full, every valid strobe moves all four stages by one
    task automatic send_rec(input insn_rec_t r);
        valid = 1'b1;
        rec   = r;
        tick();
        valid = 1'b0;
        for (int s = PIPELINE_DEPTH - 1; s > 0; s--) begin
            exp_vld[s]  = exp_vld[s-1];
            exp_insn[s] = exp_insn[s-1];
        end
        exp_vld[STAGE_IF]  = 1'b1;
        exp_insn[STAGE_IF] = r.insn;
        check_wb();
    endtask

    task automatic send_filler();
        send_rec(make_rec(rand_insn(), 1'b0));
    endtask

    // Without a strobe the stages must hold
    task automatic idle(input int n);
        repeat (n) begin
            tick();
            check_wb();
        end
    endtask

    // The fill after reset or a flush is three steps of empty stages
    task automatic finish_fill();
        repeat (PIPELINE_DEPTH - 1) begin
            tick();
        end
        for (int s = 0; s < PIPELINE_DEPTH; s++) begin
            exp_vld[s] = 1'b0;
        end
    endtask

    task automatic ride_out_flush();
        tick();
        check_bit("wb_o.valid", wb.valid, 1'b0);
        finish_fill();
    endtask

    // CSR effects land as the record enters WB, so push it all the way
    task automatic retire_csr(input csr_wr_t w0, input csr_wr_t w1);
        insn_rec_t r;
        r           = make_rec(rand_insn(), 1'b0);
        r.csr_wr[0] = w0;
        r.csr_wr[1] = w1;
        send_rec(r);
        repeat (PIPELINE_DEPTH - 1) begin
            send_filler();
        end
    endtask

    // Counts cycles until the pulse shows and gives -1 when the limit runs out
    task automatic wait_irq_taken(output int cycles);
        cycles = -1;
        for (int n = 1; n <= WAIT_LIMIT && cycles < 0; n++) begin
            tick();
            if (irq_taken) begin
                cycles = n;
            end
        end
    endtask

    task automatic wait_debug_taken(output int cycles);
        cycles = -1;
        for (int n = 1; n <= WAIT_LIMIT && cycles < 0; n++) begin
            tick();
            if (debug_taken) begin
                cycles = n;
            end
        end
    endtask

    task automatic begin_test();
        test_err_base = err_cnt;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err_base) begin
            $display("test %-16s ok", name);
            tests_passed++;
        end else begin
            $display("test %-16s FAILED with %0d errors", name, err_cnt - test_err_base);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_flow();
        insn_rec_t r [3];
        begin_test();
        check_bit("flush_o", flush, 1'b0);
        check_bit("irq_taken_o", irq_taken, 1'b0);
        check_bit("debug_taken_o", debug_taken, 1'b0);
        check_bit("wb_o.valid", wb.valid, 1'b0);
        finish_fill();
        for (int i = 0; i < 3; i++) begin
            r[i] = make_rec(rand_insn(), 1'b0);
        end
        // Gaps between the strobes must not move anything
        send_rec(r[0]);
        idle(2);
        send_rec(r[1]);
        idle(1);
        send_rec(r[2]);
        idle(3);
        repeat (3) begin
            send_filler();
        end
        check_insn("wb_o.rec.insn", wb.rec.insn, r[2].insn);
        idle(4);
        end_test("reset_flow");
    endtask

    task automatic test_irq_take();
        insn_rec_t r;
        int        cycles;
        begin_test();
        r           = make_rec(rand_insn(), 1'b0);
        r.csr_wr[0] = csr_write(CSR_MIE, 32'h0000_0880);
        send_rec(r);
        retire_csr('0, csr_write(CSR_MSTATUS, MSTATUS_MIE));
        // Bit 3 is pending but not in mie, so 11 is the cause
        irq = 32'h0000_0808;
        wait_irq_taken(cycles);
        expect_pulse("irq_taken_o", cycles, 3);
        check_cause("irq_cause_o", irq_cause, irq_cause_t'(11));
        check_bit("flush_o", flush, 1'b1);
        tick();
        check_bit("irq_taken_o", irq_taken, 1'b0);
        check_bit("wb_o.valid", wb.valid, 1'b0);
        finish_fill();
        end_test("irq_take");
    endtask

    task automatic test_irq_masking();
        int cycles;
        begin_test();
        // The irq is still pending but trap entry dropped the enable
        wait_irq_taken(cycles);
        expect_no_pulse("irq_taken_o after a take", cycles);
        // An mstatus write with every bit but MIE set
        retire_csr(csr_write(CSR_MSTATUS, ~MSTATUS_MIE), '0);
        wait_irq_taken(cycles);
        expect_no_pulse("irq_taken_o with MIE clear", cycles);
        irq = '0;
        // Both writes sit in one record and mie now leaves out bits 3 and 11
        retire_csr(csr_write(CSR_MIE, 32'h0000_0020), csr_write(CSR_MSTATUS, MSTATUS_MIE));
        irq = 32'h0000_0808;
        wait_irq_taken(cycles);
        expect_no_pulse("irq_taken_o outside mie", cycles);
        irq = '0;
        end_test("irq_masking");
    endtask

    task automatic test_irq_lsu_wait();
        insn_rec_t mem_rec;
        int        cycles;
        begin_test();
        retire_csr(csr_write(CSR_MIE, 32'h0010_0800), csr_write(CSR_MSTATUS, MSTATUS_MIE));
        mem_rec       = make_rec(rand_insn(), 1'b0);
        mem_rec.rmask = 4'hf;
        send_rec(mem_rec);
        send_filler();
        // The load now sits in EX and is counted one cycle later
        idle(1);
        // Bits 11 and 20 are enabled and the lower one wins, bit 0 is not enabled
        irq = 32'h0010_0801;
        wait_irq_taken(cycles);
        expect_no_pulse("irq_taken_o with a load in flight", cycles);
        send_filler();
        wait_irq_taken(cycles);
        expect_pulse("irq_taken_o after the load drained", cycles, 0);
        check_cause("irq_cause_o", irq_cause, irq_cause_t'(11));
        check_bit("flush_o", flush, 1'b1);
        irq = '0;
        ride_out_flush();
        end_test("irq_lsu_wait");
    endtask

    task automatic test_debug();
        int cycles;
        begin_test();
        debug_req = 1'b1;
        wait_debug_taken(cycles);
        expect_pulse("debug_taken_o", cycles, 2);
        debug_req = 1'b0;
        tick();
        check_bit("debug_taken_o", debug_taken, 1'b0);
        check_bit("flush_o", flush, 1'b1);
        ride_out_flush();
        // Records retired in debug mode until the first one reaches WB
        repeat (PIPELINE_DEPTH) begin
            send_rec(make_rec(rand_insn(), 1'b1));
        end
        debug_req = 1'b1;
        wait_debug_taken(cycles);
        expect_no_pulse("debug_taken_o in debug mode", cycles);
        debug_req = 1'b0;
        // dret still carries the flag yet leaves debug mode
        send_rec(make_rec(INSN_DRET, 1'b1));
        repeat (PIPELINE_DEPTH - 1) begin
            send_filler();
        end
        check_insn("wb_o.rec.insn", wb.rec.insn, INSN_DRET);
        debug_req = 1'b1;
        wait_debug_taken(cycles);
        expect_pulse("debug_taken_o after dret", cycles, 2);
        debug_req = 1'b0;
        tick();
        check_bit("flush_o", flush, 1'b1);
        ride_out_flush();
        end_test("debug");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int n;
        valid        = 1'b0;
        rec          = '0;
        irq          = '0;
        debug_req    = 1'b0;
        err_cnt      = 0;
        tests_passed = 0;
        tests_failed = 0;
        lfsr_q       = 32'hd37c;
        for (int s = 0; s < PIPELINE_DEPTH; s++) begin
            exp_vld[s]  = 1'b0;
            exp_insn[s] = '0;
        end

        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was still active after %0d cycles", WAIT_LIMIT);
            err_cnt++;
        end

        test_reset_flow();
        test_irq_take();
        test_irq_masking();
        test_irq_lsu_wait();
        test_debug();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
logic/shell_pkg.sv
logic/shell_pipeline.sv
logic/csr_tracker.sv
logic/irq_arbiter.sv
logic/debug_ctrl.sv
logic/shell_controller.sv
logic/shell_top.sv
tb/tb_clk_gen.sv
tb/shell_tb.sv
